// File: xt_bus_pkg.sv
/*
 * Shared constants and bus types for the XT peripheral glue.
 * Every module in the glue takes its types and port constants from here.
 */
`default_nettype none

package xt_bus_pkg;

    // bus widths
    localparam int addr_width = 20;
    localparam int data_width = 8;

    // I/O port bases
    localparam logic [15:0] ems_port_base = 16'h0260;
    localparam logic [15:0] lpt_port_base = 16'h0378;

    // EMS page map
    localparam int ems_page_count = 4;
    localparam int ems_map_width  = 7;
    localparam logic [data_width-1:0] ems_disable_code = 8'hFF;

    // high address nibble of the EMS frame, by window setting
    localparam logic [3:0] ems_window_a = 4'hA;
    localparam logic [3:0] ems_window_c = 4'hC;
    localparam logic [3:0] ems_window_d = 4'hD;

    // chipset device slots, address bits 7:5 in the low I/O space
    localparam logic [2:0] slot_dma      = 3'd0;
    localparam logic [2:0] slot_pic      = 3'd1;
    localparam logic [2:0] slot_pit      = 3'd2;
    localparam logic [2:0] slot_ppi      = 3'd3;
    localparam logic [2:0] slot_dma_page = 3'd4;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;

    // one CPU bus cycle, strobes active low
    typedef struct packed {
        addr_t address;
        data_t write_data;
        logic  io_read_n;
        logic  io_write_n;
        logic  memory_read_n;
        logic  address_enable_n;
    } bus_cycle_t;

    // decoded device selects, active high
    typedef struct packed {
        logic dma;
        logic pic;
        logic pit;
        logic ppi;
        logic dma_page;
        logic ems;
        logic lpt;
    } io_select_t;

    typedef struct packed {
        logic                     enable;
        logic [ems_map_width-1:0] map;
    } ems_map_t;

    // one hit bit per 16 KB EMS window
    typedef logic [ems_page_count-1:0] ems_bank_t;

endpackage

`default_nettype wire

// File: io_address_decoder.sv
/*
 * I/O port decode. Turns the CPU address and strobes into active-high
 * selects for the chipset devices, the EMS map ports and the printer port.
 * Purely combinational, so the selects follow the bus in the same cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module io_address_decoder (
    input  xt_bus_pkg::bus_cycle_t bus_i,
    input  logic                   ems_enabled_i,
    output xt_bus_pkg::io_select_t select_o
);
    import xt_bus_pkg::*;

    logic       iorq;
    logic       io_space;
    logic       chipset_space;
    logic [2:0] slot;

    // any I/O cycle, read or write
    assign iorq = ~bus_i.io_read_n | ~bus_i.io_write_n;

    // CPU owns the bus in a non-DMA cycle
    assign io_space = iorq & ~bus_i.address_enable_n;

    // chipset lives in 000h..0FFh
    assign chipset_space = io_space & ~bus_i.address[9] & ~bus_i.address[8];
    assign slot          = bus_i.address[7:5];

    always_comb begin
        select_o = '0;

        if (chipset_space) begin
            case (slot)
                slot_dma:      select_o.dma      = 1'b1;
                slot_pic:      select_o.pic      = 1'b1;
                slot_pit:      select_o.pit      = 1'b1;
                slot_ppi:      select_o.ppi      = 1'b1;
                slot_dma_page: select_o.dma_page = 1'b1;
                default:       ;
            endcase
        end

        // EMS map ports 260h..263h when EMS is switched on
        select_o.ems = io_space & ems_enabled_i
                     & (bus_i.address[15:2] == ems_port_base[15:2]);

        // 378h..37Fh
        select_o.lpt = io_space
                     & (bus_i.address[15:3] == lpt_port_base[15:3]);
    end

endmodule

`default_nettype wire

// File: ems_page_mapper.sv
/*
 * EMS page map registers at ports 260h..263h. Holds the enable bit and map
 * of each page, returns the addressed page for read-back and flags which
 * 16 KB window a memory cycle falls into.
 */
`timescale 1ns/1ps
`default_nettype none

module ems_page_mapper (
    input  logic                   clock,
    input  logic                   reset,
    input  xt_bus_pkg::bus_cycle_t bus_i,
    input  logic                   ems_select_i,
    input  logic [1:0]             window_setting_i,
    output xt_bus_pkg::data_t      readback_o,
    output xt_bus_pkg::ems_bank_t  bank_hit_o
);
    import xt_bus_pkg::*;

    ems_map_t   pages [ems_page_count];
    logic [1:0] page_index;
    logic       iorq;
    logic [3:0] window_nibble;
    data_t      write_data;

    assign page_index = bus_i.address[1:0];
    assign write_data = bus_i.write_data;
    assign iorq       = ~bus_i.io_read_n | ~bus_i.io_write_n;

    // FFh unmaps a page, 00h..7Fh maps it, anything else is ignored
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int n = 0; n < ems_page_count; n++) begin
                pages[n] <= '0;
            end
        end else if (ems_select_i && !bus_i.io_write_n) begin
            if (write_data == ems_disable_code) begin
                pages[page_index].enable <= 1'b0;
                pages[page_index].map    <= '1;
            end else if (!write_data[data_width-1]) begin
                pages[page_index].enable <= 1'b1;
                pages[page_index].map    <= write_data[ems_map_width-1:0];
            end
        end
    end

    // unmapped pages read back as FFh
    always_comb begin
        if (pages[page_index].enable) begin
            readback_o = {{(data_width - ems_map_width){1'b0}}, pages[page_index].map};
        end else begin
            readback_o = ems_disable_code;
        end
    end

    // settings 2 and 3 both select the Dxxxx frame
    always_comb begin
        case (window_setting_i)
            2'd0:    window_nibble = ems_window_a;
            2'd1:    window_nibble = ems_window_c;
            default: window_nibble = ems_window_d;
        endcase
    end

    // memory cycles only
    always_comb begin
        for (int n = 0; n < ems_page_count; n++) begin
            bank_hit_o[n] = !iorq && pages[n].enable
                          && (bus_i.address[19:14] == {window_nibble, 2'(n)});
        end
    end

endmodule

`default_nettype wire

// File: keyboard_port_sync.sv
/*
 * Keyboard side of the PPI. Brings the keyboard interrupt and scan code
 * in through two register stages and turns a rising port B bit 6 into a
 * single-cycle keyboard reset request.
 */
`timescale 1ns/1ps
`default_nettype none

module keyboard_port_sync (
    input  logic              clock,
    input  logic              reset,
    input  logic              keyboard_irq_i,
    input  xt_bus_pkg::data_t keycode_i,
    input  xt_bus_pkg::data_t ppi_port_b_i,
    output logic              kbd_interrupt_o,
    output xt_bus_pkg::data_t port_a_o,
    output logic              kbd_reset_request_o
);
    import xt_bus_pkg::*;

    logic  irq_meta;
    data_t keycode_ff;
    logic  reset_bit;
    logic  reset_bit_prev;

    // port B bit 6 releases the keyboard clock line
    assign reset_bit = ppi_port_b_i[6];

    // two stages on the interrupt
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            irq_meta        <= 1'b0;
            kbd_interrupt_o <= 1'b0;
        end else begin
            irq_meta        <= keyboard_irq_i;
            kbd_interrupt_o <= irq_meta;
        end
    end

    // scan code kept in step with the interrupt
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            keycode_ff <= '0;
            port_a_o   <= '0;
        end else begin
            keycode_ff <= keycode_i;
            port_a_o   <= keycode_ff;
        end
    end

    // rising edge of the reset bit
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            reset_bit_prev      <= 1'b0;
            kbd_reset_request_o <= 1'b0;
        end else begin
            reset_bit_prev      <= reset_bit;
            kbd_reset_request_o <= reset_bit & ~reset_bit_prev;
        end
    end

endmodule

`default_nettype wire

// File: bus_read_mux.sv
/*
 * Read side of the glue. Holds the printer data latch and picks which
 * device drives the CPU data bus, interrupt acknowledge first.
 * data_out_valid_o is high whenever one of the sources is chosen.
 */
`timescale 1ns/1ps
`default_nettype none

module bus_read_mux (
    input  logic                   clock,
    input  logic                   reset,
    input  xt_bus_pkg::bus_cycle_t bus_i,
    input  xt_bus_pkg::io_select_t select_i,
    input  logic                   interrupt_acknowledge_n_i,
    input  xt_bus_pkg::data_t      pic_data_i,
    input  xt_bus_pkg::data_t      pit_data_i,
    input  xt_bus_pkg::data_t      ppi_data_i,
    input  xt_bus_pkg::data_t      ems_data_i,
    output xt_bus_pkg::data_t      data_out_o,
    output logic                   data_out_valid_o
);
    import xt_bus_pkg::*;

    data_t lpt_data;
    logic  io_read;

    assign io_read = ~bus_i.io_read_n;

    // printer data latch, idles high like a floating port
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data <= 8'hFF;
        end else if (select_i.lpt && !bus_i.io_write_n) begin
            lpt_data <= bus_i.write_data;
        end
    end

    // fixed priority, first match wins
    always_comb begin
        data_out_valid_o = 1'b1;
        data_out_o       = '0;

        if (!interrupt_acknowledge_n_i) begin
            // vector comes from the PIC
            data_out_o = pic_data_i;
        end else if (select_i.pic && io_read) begin
            data_out_o = pic_data_i;
        end else if (select_i.pit && io_read) begin
            data_out_o = pit_data_i;
        end else if (select_i.ppi && io_read) begin
            data_out_o = ppi_data_i;
        end else if (select_i.ems && io_read) begin
            data_out_o = ems_data_i;
        end else if (select_i.lpt && io_read) begin
            data_out_o = lpt_data;
        end else begin
            // nobody here answers
            data_out_valid_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: xt_peripheral_glue.sv
/*
 * Top of the XT peripheral glue. Connects port decode, EMS paging,
 * keyboard path and read steering. The chipset devices sit outside and
 * see only their active-low selects and the steered read data.
 */
`timescale 1ns/1ps
`default_nettype none

module xt_peripheral_glue (
    input  logic                   clock,
    input  logic                   reset,
    // CPU bus
    input  xt_bus_pkg::bus_cycle_t bus_i,
    input  logic                   interrupt_acknowledge_n_i,
    // EMS setup
    input  logic                   ems_enabled_i,
    input  logic [1:0]             ems_window_i,
    // chipset read data
    input  xt_bus_pkg::data_t      pic_data_i,
    input  xt_bus_pkg::data_t      pit_data_i,
    input  xt_bus_pkg::data_t      ppi_data_i,
    // keyboard
    input  logic                   keyboard_irq_i,
    input  xt_bus_pkg::data_t      keycode_i,
    input  xt_bus_pkg::data_t      ppi_port_b_i,
    // chipset selects
    output logic                   dma_cs_n_o,
    output logic                   pic_cs_n_o,
    output logic                   pit_cs_n_o,
    output logic                   ppi_cs_n_o,
    output logic                   dma_page_cs_n_o,
    output xt_bus_pkg::ems_bank_t  ems_bank_o,
    // keyboard side of the PPI
    output logic                   kbd_interrupt_o,
    output xt_bus_pkg::data_t      port_a_o,
    output logic                   kbd_reset_request_o,
    output logic                   clear_keycode_o,
    // CPU read data
    output xt_bus_pkg::data_t      data_out_o,
    output logic                   data_out_valid_o
);
    import xt_bus_pkg::*;

    io_select_t select;
    data_t      ems_readback;

    io_address_decoder u_decoder (
        .bus_i         (bus_i),
        .ems_enabled_i (ems_enabled_i),
        .select_o      (select)
    );

    // chipset parts want active-low selects
    assign dma_cs_n_o      = ~select.dma;
    assign pic_cs_n_o      = ~select.pic;
    assign pit_cs_n_o      = ~select.pit;
    assign ppi_cs_n_o      = ~select.ppi;
    assign dma_page_cs_n_o = ~select.dma_page;

    ems_page_mapper u_ems (
        .clock            (clock),
        .reset            (reset),
        .bus_i            (bus_i),
        .ems_select_i     (select.ems),
        .window_setting_i (ems_window_i),
        .readback_o       (ems_readback),
        .bank_hit_o       (ems_bank_o)
    );

    keyboard_port_sync u_keyboard (
        .clock               (clock),
        .reset               (reset),
        .keyboard_irq_i      (keyboard_irq_i),
        .keycode_i           (keycode_i),
        .ppi_port_b_i        (ppi_port_b_i),
        .kbd_interrupt_o     (kbd_interrupt_o),
        .port_a_o            (port_a_o),
        .kbd_reset_request_o (kbd_reset_request_o)
    );

    // port B bit 7 acknowledges the scan code
    assign clear_keycode_o = ppi_port_b_i[7];

    bus_read_mux u_read_mux (
        .clock                     (clock),
        .reset                     (reset),
        .bus_i                     (bus_i),
        .select_i                  (select),
        .interrupt_acknowledge_n_i (interrupt_acknowledge_n_i),
        .pic_data_i                (pic_data_i),
        .pit_data_i                (pit_data_i),
        .ppi_data_i                (ppi_data_i),
        .ems_data_i                (ems_readback),
        .data_out_o                (data_out_o),
        .data_out_valid_o          (data_out_valid_o)
    );

endmodule

`default_nettype wire

// File: tb_glue_checker.sv
/*
 * Watches the glue ports on every falling clock edge and compares them with
 * a reference model of the port decode, EMS pages, printer latch and
 * keyboard pipes. Prints one line per test when the testbench marks its end.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_glue_checker (
    input  logic                   clock,
    input  logic                   reset,
    input  xt_bus_pkg::bus_cycle_t bus_i,
    input  logic                   iack_n_i,
    input  logic                   ems_enabled_i,
    input  logic [1:0]             ems_window_i,
    input  logic [23:0]            device_data_i,
    input  logic                   keyboard_irq_i,
    input  xt_bus_pkg::data_t      keycode_i,
    input  xt_bus_pkg::data_t      ppi_port_b_i,
    input  logic [4:0]             cs_n_i,
    input  xt_bus_pkg::ems_bank_t  ems_bank_i,
    input  logic                   kbd_interrupt_i,
    input  xt_bus_pkg::data_t      port_a_i,
    input  logic                   kbd_reset_request_i,
    input  logic                   clear_keycode_i,
    input  xt_bus_pkg::data_t      data_out_i,
    input  logic                   data_out_valid_i,
    input  logic [2:0]             test_index_i,
    input  logic                   test_done_i,
    input  logic                   run_done_i,
    output int                     error_count_o
);
    import xt_bus_pkg::*;

    // reference state
    logic       page_enable [4];
    logic [6:0] page_map [4];
    data_t      lpt_model;
    logic [1:0] irq_pipe;
    data_t      code_pipe [2];
    logic       request_model;
    logic       reset_bit_prev;
    int         check_count;
    int         test_checks;
    int         test_errors;
    bit         summary_done;

    function automatic string test_name(input logic [2:0] index);
        case (index)
            3'd0:    return "reset values";
            3'd1:    return "chip selects";
            3'd2:    return "ems paging";
            3'd3:    return "read priority";
            default: return "keyboard path";
        endcase
    endfunction

    task automatic compare(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            error_count_o++;
            test_errors++;
            $display("[ERROR] t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    always @(negedge clock) begin : check_cycle
        logic       iorq;
        logic       cpu_io;
        logic       low_space;
        logic       reading;
        logic       ems_sel;
        logic       lpt_sel;
        logic [2:0] slot;
        logic [1:0] page;
        logic [3:0] nibble;
        logic [4:0] exp_cs_n;
        ems_bank_t  exp_bank;
        data_t      exp_readback;
        data_t      exp_data;
        logic       exp_valid;

        if (reset) begin
            for (int n = 0; n < 4; n++) begin
                page_enable[n] = 1'b0;
                page_map[n]    = '0;
            end
            lpt_model      = 8'hFF;
            irq_pipe       = '0;
            code_pipe[0]   = '0;
            code_pipe[1]   = '0;
            request_model  = 1'b0;
            reset_bit_prev = 1'b0;
        end else begin
            iorq      = !bus_i.io_read_n || !bus_i.io_write_n;
            cpu_io    = iorq && !bus_i.address_enable_n;
            low_space = cpu_io && bus_i.address[9:8] == 2'b00;
            reading   = !bus_i.io_read_n;
            slot      = bus_i.address[7:5];
            page      = bus_i.address[1:0];
            // 260h..263h and 378h..37Fh
            ems_sel   = cpu_io && ems_enabled_i && bus_i.address[15:2] == 14'h098;
            lpt_sel   = cpu_io && bus_i.address[15:3] == 13'h06F;

            // dma in the msb down to the page register in the lsb
            exp_cs_n = 5'b11111;
            if (low_space && slot <= 3'd4) begin
                exp_cs_n[3'd4 - slot] = 1'b0;
            end

            case (ems_window_i)
                2'd0:    nibble = 4'hA;
                2'd1:    nibble = 4'hC;
                default: nibble = 4'hD;
            endcase
            for (int n = 0; n < 4; n++) begin
                exp_bank[n] = !iorq && page_enable[n] && bus_i.address[19:16] == nibble
                            && bus_i.address[15:14] == 2'(n);
            end
            exp_readback = page_enable[page] ? {1'b0, page_map[page]} : 8'hFF;

            exp_valid = 1'b1;
            if (!iack_n_i) begin
                exp_data = device_data_i[23:16];
            end else if (reading && low_space && slot == 3'd1) begin
                exp_data = device_data_i[23:16];
            end else if (reading && low_space && slot == 3'd2) begin
                exp_data = device_data_i[15:8];
            end else if (reading && low_space && slot == 3'd3) begin
                exp_data = device_data_i[7:0];
            end else if (reading && ems_sel) begin
                exp_data = exp_readback;
            end else if (reading && lpt_sel) begin
                exp_data = lpt_model;
            end else begin
                exp_data  = 8'h00;
                exp_valid = 1'b0;
            end

            compare("{dma,pic,pit,ppi,dma_page}_cs_n_o", 8'(exp_cs_n), 8'(cs_n_i));
            compare("ems_bank_o", 8'(exp_bank), 8'(ems_bank_i));
            compare("data_out_o", exp_data, data_out_i);
            compare("data_out_valid_o", 8'(exp_valid), 8'(data_out_valid_i));
            compare("kbd_interrupt_o", 8'(irq_pipe[1]), 8'(kbd_interrupt_i));
            compare("port_a_o", code_pipe[1], port_a_i);
            compare("kbd_reset_request_o", 8'(request_model), 8'(kbd_reset_request_i));
            compare("clear_keycode_o", 8'(ppi_port_b_i[7]), 8'(clear_keycode_i));

            // state for the next rising edge
            if (ems_sel && !bus_i.io_write_n) begin
                if (bus_i.write_data == 8'hFF) begin
                    page_enable[page] = 1'b0;
                    page_map[page]    = 7'h7F;
                end else if (bus_i.write_data < 8'h80) begin
                    page_enable[page] = 1'b1;
                    page_map[page]    = bus_i.write_data[6:0];
                end
            end
            if (lpt_sel && !bus_i.io_write_n) begin
                lpt_model = bus_i.write_data;
            end
            irq_pipe       = {irq_pipe[0], keyboard_irq_i};
            code_pipe[1]   = code_pipe[0];
            code_pipe[0]   = keycode_i;
            request_model  = ppi_port_b_i[6] && !reset_bit_prev;
            reset_bit_prev = ppi_port_b_i[6];

            if (test_done_i) begin
                $display("test %0d %s: %0d checks, %0d errors", test_index_i,
                         test_name(test_index_i), test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
            if (run_done_i && !summary_done) begin
                if (check_count == 0) begin
                    $display("no comparisons were made during the run");
                    error_count_o++;
                end
                $display("total: %0d checks, %0d errors", check_count, error_count_o);
                summary_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_xt_peripheral_glue.sv
/*
 * Testbench top for the XT peripheral glue. Makes clock and reset, drives
 * LFSR-based bus, EMS and keyboard traffic test by test, and leaves the
 * comparing to tb_glue_checker.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_xt_peripheral_glue;
    import xt_bus_pkg::*;

    localparam int clock_period   = 10;
    localparam int reset_cycles   = 10;
    localparam int test_count     = 5;
    localparam int test_cycles    = 400;
    localparam int timeout_cycles = reset_cycles + test_count * (test_cycles + 3) + 100;

    logic        clock;
    logic        reset;
    bus_cycle_t  bus_i;
    logic        interrupt_acknowledge_n_i;
    logic        ems_enabled_i;
    logic [1:0]  ems_window_i;
    data_t       pic_data_i;
    data_t       pit_data_i;
    data_t       ppi_data_i;
    logic        keyboard_irq_i;
    data_t       keycode_i;
    data_t       ppi_port_b_i;
    logic        dma_cs_n_o;
    logic        pic_cs_n_o;
    logic        pit_cs_n_o;
    logic        ppi_cs_n_o;
    logic        dma_page_cs_n_o;
    ems_bank_t   ems_bank_o;
    logic        kbd_interrupt_o;
    data_t       port_a_o;
    logic        kbd_reset_request_o;
    logic        clear_keycode_o;
    data_t       data_out_o;
    logic        data_out_valid_o;
    logic [2:0]  test_index;
    logic        test_done;
    logic        run_done;
    int          error_count;
    logic [15:0] lfsr_state;

    xt_peripheral_glue u_dut (.*);

    tb_glue_checker u_checker (
        .clock               (clock),
        .reset               (reset),
        .bus_i               (bus_i),
        .iack_n_i            (interrupt_acknowledge_n_i),
        .ems_enabled_i       (ems_enabled_i),
        .ems_window_i        (ems_window_i),
        .device_data_i       ({pic_data_i, pit_data_i, ppi_data_i}),
        .keyboard_irq_i      (keyboard_irq_i),
        .keycode_i           (keycode_i),
        .ppi_port_b_i        (ppi_port_b_i),
        .cs_n_i              ({dma_cs_n_o, pic_cs_n_o, pit_cs_n_o,
                               ppi_cs_n_o, dma_page_cs_n_o}),
        .ems_bank_i          (ems_bank_o),
        .kbd_interrupt_i     (kbd_interrupt_o),
        .port_a_i            (port_a_o),
        .kbd_reset_request_i (kbd_reset_request_o),
        .clear_keycode_i     (clear_keycode_o),
        .data_out_i          (data_out_o),
        .data_out_valid_i    (data_out_valid_o),
        .test_index_i        (test_index),
        .test_done_i         (test_done),
        .run_done_i          (run_done),
        .error_count_o       (error_count)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // x^16 + x^14 + x^13 + x^11, shifting left
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int n = 0; n < count; n++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // leans toward chipset ports, EMS ports, the printer port and EMS frames
    task automatic pick_address(output addr_t address);
        logic [31:0] kind;
        logic [31:0] bits;
        logic [3:0]  nibble;
        take_bits(3, kind);
        take_bits(20, bits);
        nibble = bits[19] ? 4'hD : (bits[18] ? 4'hC : 4'hA);
        case (kind[2:0])
            3'd0, 3'd1: address = {bits[19:10], 2'b00, bits[7:0]};
            3'd2, 3'd3: address = {bits[19:16], ems_port_base[15:2], bits[1:0]};
            3'd4:       address = {bits[19:16], lpt_port_base[15:3], bits[2:0]};
            3'd5, 3'd6: address = {nibble, bits[15:0]};
            default:    address = bits[19:0];
        endcase
    endtask

    task automatic random_cycle(input int mode);
        addr_t       address;
        logic [31:0] data;
        logic [31:0] ctrl;
        logic [31:0] port_b;
        data_t       write_data;
        @(posedge clock);
        pick_address(address);
        take_bits(32, data);
        take_bits(25, ctrl);
        take_bits(8, port_b);
        write_data = ctrl[7:0];
        // EMS test favours the disable code and valid map values
        if (mode == 2 && ctrl[9:8] == 2'd0) begin
            write_data = ems_disable_code;
        end else if (mode == 2 && ctrl[9]) begin
            write_data[7] = 1'b0;
        end
        bus_i.address    <= address;
        bus_i.write_data <= write_data;
        case (ctrl[11:10])
            2'd0:    {bus_i.io_read_n, bus_i.io_write_n} <= 2'b01;
            2'd1:    {bus_i.io_read_n, bus_i.io_write_n} <= 2'b10;
            2'd2:    {bus_i.io_read_n, bus_i.io_write_n} <= 2'b11;
            default: {bus_i.io_read_n, bus_i.io_write_n} <= ctrl[13:12];
        endcase
        bus_i.address_enable_n    <= (ctrl[15:14] == 2'b11);
        bus_i.memory_read_n       <= ctrl[16];
        keyboard_irq_i            <= ctrl[17];
        ems_window_i              <= ctrl[19:18];
        ems_enabled_i             <= (ctrl[22:20] != 3'd0);
        interrupt_acknowledge_n_i <= (mode != 3 || ctrl[24:23] != 2'd0);
        pic_data_i                <= data[31:24];
        pit_data_i                <= data[23:16];
        ppi_data_i                <= data[15:8];
        keycode_i                 <= data[7:0];
        ppi_port_b_i              <= port_b[7:0];
    endtask

    // reads the four EMS ports and the printer port in turn
    task automatic reset_read(input int n);
        @(posedge clock);
        bus_i.address          <= (n % 5 == 4) ? {4'h0, lpt_port_base}
                                               : {4'h0, ems_port_base + 16'(n % 4)};
        bus_i.io_read_n        <= 1'b0;
        bus_i.address_enable_n <= 1'b0;
    endtask

    task automatic end_test();
        @(posedge clock);
        bus_i.io_read_n  <= 1'b1;
        bus_i.io_write_n <= 1'b1;
        test_done        <= 1'b1;
        @(posedge clock);
        test_done <= 1'b0;
    endtask

    initial begin
        reset                     <= 1'b1;
        bus_i                     <= '{address: '0, write_data: '0, default: 1'b1};
        interrupt_acknowledge_n_i <= 1'b1;
        ems_enabled_i             <= 1'b1;
        ems_window_i              <= 2'd0;
        pic_data_i                <= '0;
        pit_data_i                <= '0;
        ppi_data_i                <= '0;
        keyboard_irq_i            <= 1'b0;
        keycode_i                 <= '0;
        ppi_port_b_i              <= '0;
        test_index                <= '0;
        test_done                 <= 1'b0;
        run_done                  <= 1'b0;
        lfsr_state = 16'd24050;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        for (int n = 0; n < 20; n++) begin
            reset_read(n);
        end
        end_test();
        // 1 chip selects, 2 EMS paging, 3 read priority, 4 keyboard path
        for (int t = 1; t < test_count; t++) begin
            test_index <= 3'(t);
            repeat (test_cycles) random_cycle(t);
            end_test();
        end
        run_done <= 1'b1;
        repeat (2) @(posedge clock);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(timeout_cycles * clock_period);
        $display("watchdog expired before the last test finished");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: xt_peripheral_glue.f
xt_bus_pkg.sv
io_address_decoder.sv
ems_page_mapper.sv
keyboard_port_sync.sv
bus_read_mux.sv
xt_peripheral_glue.sv
tb_glue_checker.sv
tb_xt_peripheral_glue.sv

// File: run_sim.sh
#!/bin/sh
# Builds the XT peripheral glue testbench with Verilator and runs it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

log=sim.log
build=obj_dir

verilator --binary --timing --timescale 1ns/1ps \
    -f xt_peripheral_glue.f \
    --top-module tb_xt_peripheral_glue \
    -Mdir "$build" -o sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build/sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$log"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
